// ==== displayController.sv ====
// ILI9341 8080 display controller
`timescale 1ns/10ps
`include "lcdSubsystem_defines.svh"

module displayController
(
    input  logic             aclk,
    input  logic             resetn,
    input  logic             streamValid,
    output logic             streamReady,
    input  lcdPkg::stream_t  stream,
    output logic [7:0]       lcdData,
    output logic             lcdWr,
    output logic             lcdCs,
    output logic             lcdDc
);
    import lcdPkg::*;

    localparam int INIT_SIZE = 37;
    localparam int DIV_WIDTH = $clog2(`LCD_CLOCK_DIV + 2);

    // Orientation dependent entries
    localparam logic [7:0] MADCTL      = `LCD_LANDSCAPE ? 8'h28 : 8'h08;
    localparam logic [7:0] COL_END_HI  = `LCD_LANDSCAPE ? 8'h01 : 8'h00;
    localparam logic [7:0] COL_END_LO  = `LCD_LANDSCAPE ? 8'h3F : 8'hEF;
    localparam logic [7:0] PAGE_END_HI = `LCD_LANDSCAPE ? 8'h00 : 8'h01;
    localparam logic [7:0] PAGE_END_LO = `LCD_LANDSCAPE ? 8'hEF : 8'h3F;

    // Each entry is {dc, byte}, dc low for a command
    localparam logic [8:0] INIT_TABLE [INIT_SIZE] = '{
        {1'b0, 8'h01}, {1'b1, 8'h00},
        {1'b0, 8'h28}, {1'b1, 8'h00},
        {1'b0, 8'hC0}, {1'b1, 8'h23},
        {1'b0, 8'hC1}, {1'b1, 8'h10},
        {1'b0, 8'hC5}, {1'b1, 8'h2B}, {1'b1, 8'h2B},
        {1'b0, 8'hC7}, {1'b1, 8'hC0},
        {1'b0, 8'h36}, {1'b1, MADCTL},
        {1'b0, 8'h3A}, {1'b1, 8'h55},
        {1'b0, 8'hB1}, {1'b1, 8'h00}, {1'b1, 8'h1B},
        {1'b0, 8'hB7}, {1'b1, 8'h07},
        {1'b0, 8'h11}, {1'b1, 8'h00},
        {1'b0, 8'h29}, {1'b1, 8'h00},
        {1'b0, 8'h2A}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b1, COL_END_HI}, {1'b1, COL_END_LO},
        {1'b0, 8'h2B}, {1'b1, 8'h00}, {1'b1, 8'h00}, {1'b1, PAGE_END_HI}, {1'b1, PAGE_END_LO},
        {1'b0, 8'h2C}
    };

    lcdState_e            state;
    logic [5:0]           initIdx;
    logic [DIV_WIDTH-1:0] divCnt;
    logic                 tick;
    pixel_t               pixelReg;
    logic                 pixelValid;

    assign tick        = (divCnt == DIV_WIDTH'(`LCD_CLOCK_DIV));
    assign streamReady = (state != INIT) && !pixelValid;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state      <= INIT;
            initIdx    <= '0;
            divCnt     <= '0;
            pixelValid <= 1'b0;
            lcdData    <= '0;
            lcdWr      <= 1'b1;
            lcdCs      <= 1'b1;
            lcdDc      <= 1'b1;
        end
        else
        begin
            lcdCs  <= 1'b0;
            divCnt <= tick ? '0 : divCnt + 1'b1;

            if (streamValid && streamReady)
            begin
                pixelReg   <= stream.pixel;
                pixelValid <= 1'b1;
            end

            // wr falls on one tick and rises on the next
            if (tick)
            begin
                case (state)
                    INIT:
                    begin
                        if (lcdWr)
                        begin
                            {lcdDc, lcdData} <= INIT_TABLE[initIdx];
                            lcdWr            <= 1'b0;
                            initIdx          <= initIdx + 1'b1;
                        end
                        else
                        begin
                            lcdWr <= 1'b1;
                            if (initIdx == 6'(INIT_SIZE))
                            begin
                                state <= STREAM_HIGH;
                            end
                        end
                    end
                    STREAM_HIGH:
                    begin
                        if (lcdWr)
                        begin
                            // Bus idles high until a pixel is latched
                            if (pixelValid)
                            begin
                                lcdDc   <= 1'b1;
                                lcdData <= pixelReg[15:8];
                                lcdWr   <= 1'b0;
                            end
                        end
                        else
                        begin
                            lcdWr <= 1'b1;
                            state <= STREAM_LOW;
                        end
                    end
                    STREAM_LOW:
                    begin
                        if (lcdWr)
                        begin
                            lcdData <= pixelReg[7:0];
                            lcdWr   <= 1'b0;
                        end
                        else
                        begin
                            lcdWr      <= 1'b1;
                            pixelValid <= 1'b0;
                            state      <= STREAM_HIGH;
                        end
                    end
                    default:
                    begin
                        state <= INIT;
                    end
                endcase
            end
        end
    end

    // A low phase spans exactly one tick
    wrLowOneTick: assert property (@(posedge aclk) disable iff (!resetn)
        $fell(lcdWr) |-> !lcdWr [*(`LCD_CLOCK_DIV + 1)] ##1 lcdWr);

endmodule

// ==== frameBuffer.sv ====
// Frame buffer memory
`timescale 1ns/10ps
`include "lcdSubsystem_defines.svh"

module frameBuffer
(
    input  logic             aclk,
    input  lcdPkg::memReq_t  memReq,
    output lcdPkg::pixel_t   rdata
);
    import lcdPkg::*;

    localparam int DEPTH = 2 ** `FB_ADDR_WIDTH;

    pixel_t mem [0:DEPTH-1];

    // Single port, a request is either a write or a read
    always_ff @(posedge aclk)
    begin
        if (memReq.req)
        begin
            if (memReq.write)
            begin
                mem[memReq.addr] <= memReq.wdata;
            end
            else
            begin
                // Read data shows up the cycle after the grant
                rdata <= mem[memReq.addr];
            end
        end
    end

endmodule

// ==== hostPort.sv ====
// Host write port
`timescale 1ns/10ps
`include "lcdSubsystem_defines.svh"

module hostPort
(
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      hostWrite,
    input  logic [`FB_ADDR_WIDTH-1:0] hostAddr,
    input  lcdPkg::pixel_t            hostPixel,
    input  logic                      grant,
    output logic                      busy,
    output lcdPkg::memReq_t           memReq
);
    import lcdPkg::*;

    logic                      pending;
    logic [`FB_ADDR_WIDTH-1:0] addrReg;
    pixel_t                    pixelReg;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            pending <= 1'b0;
        end
        else if (pending)
        begin
            // Strobes are dropped while a write is waiting
            if (grant)
            begin
                pending <= 1'b0;
            end
        end
        else if (hostWrite)
        begin
            pending  <= 1'b1;
            addrReg  <= hostAddr;
            pixelReg <= hostPixel;
        end
    end

    assign busy   = pending;
    assign memReq = '{req: pending, write: 1'b1, addr: addrReg, wdata: pixelReg};

endmodule

// ==== lcdPkg.sv ====
// LCD subsystem types
`include "lcdSubsystem_defines.svh"

package lcdPkg;

    // RGB565, red in the upper bits so the high byte goes out first
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // One frame buffer access
    typedef struct packed {
        logic                      req;
        logic                      write;
        logic [`FB_ADDR_WIDTH-1:0] addr;
        pixel_t                    wdata;
    } memReq_t;

    // Pixel stream word, last marks the final pixel of a frame
    typedef struct packed {
        pixel_t pixel;
        logic   last;
    } stream_t;

    typedef enum logic [1:0] {
        INIT,
        STREAM_HIGH,
        STREAM_LOW
    } lcdState_e;

    typedef enum logic {
        HOST,
        SCAN
    } master_e;

endpackage

// ==== lcdSubsystem.f ====
+incdir+.
lcdPkg.sv
frameBuffer.sv
memArbiter.sv
hostPort.sv
scanoutReader.sv
displayController.sv
lcdSubsystem.sv
tbLcdSubsystem.sv

// ==== lcdSubsystem.sv ====
// LCD subsystem top level
`timescale 1ns/10ps
`include "lcdSubsystem_defines.svh"

module lcdSubsystem
(
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      hostWrite,
    input  logic [`FB_ADDR_WIDTH-1:0] hostAddr,
    input  lcdPkg::pixel_t            hostPixel,
    output logic                      hostBusy,
    output logic [7:0]                lcdData,
    output logic                      lcdWr,
    output logic                      lcdCs,
    output logic                      lcdDc
);
    import lcdPkg::*;

    memReq_t hostReq;
    memReq_t scanReq;
    memReq_t memReq;
    logic    hostGrant;
    logic    scanGrant;
    pixel_t  rdata;
    logic    streamValid;
    logic    streamReady;
    stream_t stream;

    frameBuffer uFrameBuffer
    (
        .aclk   (aclk),
        .memReq (memReq),
        .rdata  (rdata)
    );

    memArbiter uMemArbiter
    (
        .aclk      (aclk),
        .resetn    (resetn),
        .hostReq   (hostReq),
        .scanReq   (scanReq),
        .hostGrant (hostGrant),
        .scanGrant (scanGrant),
        .memReq    (memReq)
    );

    hostPort uHostPort
    (
        .aclk      (aclk),
        .resetn    (resetn),
        .hostWrite (hostWrite),
        .hostAddr  (hostAddr),
        .hostPixel (hostPixel),
        .grant     (hostGrant),
        .busy      (hostBusy),
        .memReq    (hostReq)
    );

    scanoutReader uScanoutReader
    (
        .aclk        (aclk),
        .resetn      (resetn),
        .grant       (scanGrant),
        .rdata       (rdata),
        .memReq      (scanReq),
        .streamValid (streamValid),
        .streamReady (streamReady),
        .stream      (stream)
    );

    displayController uDisplayController
    (
        .aclk        (aclk),
        .resetn      (resetn),
        .streamValid (streamValid),
        .streamReady (streamReady),
        .stream      (stream),
        .lcdData     (lcdData),
        .lcdWr       (lcdWr),
        .lcdCs       (lcdCs),
        .lcdDc       (lcdDc)
    );

endmodule

// ==== lcdSubsystem_defines.svh ====
// LCD subsystem parameters
`ifndef LCD_SUBSYSTEM_DEFINES_SVH
`define LCD_SUBSYSTEM_DEFINES_SVH

// Extra aclk cycles per bus tick, 0 gives one tick per cycle
`define LCD_CLOCK_DIV 0

// 1 selects landscape rotation and windows, 0 selects portrait
`define LCD_LANDSCAPE 0

// Frame buffer geometry, kept small for simulation
`define FB_WIDTH 8
`define FB_HEIGHT 4

// Must cover FB_WIDTH * FB_HEIGHT pixels
`define FB_ADDR_WIDTH 5

`endif

// ==== memArbiter.sv ====
// Frame buffer arbiter
`timescale 1ns/10ps

module memArbiter
(
    input  logic             aclk,
    input  logic             resetn,
    input  lcdPkg::memReq_t  hostReq,
    input  lcdPkg::memReq_t  scanReq,
    output logic             hostGrant,
    output logic             scanGrant,
    output lcdPkg::memReq_t  memReq
);
    import lcdPkg::*;

    master_e lastWinner;

    // Alternate on contention, otherwise serve whoever asks
    always_comb
    begin
        hostGrant = 1'b0;
        scanGrant = 1'b0;
        if (hostReq.req && scanReq.req)
        begin
            if (lastWinner == HOST)
            begin
                scanGrant = 1'b1;
            end
            else
            begin
                hostGrant = 1'b1;
            end
        end
        else
        begin
            hostGrant = hostReq.req;
            scanGrant = scanReq.req;
        end
    end

    // With no grant neither request is active, so req is low here too
    assign memReq = hostGrant ? hostReq : scanReq;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            lastWinner <= SCAN;
        end
        else if (hostGrant)
        begin
            lastWinner <= HOST;
        end
        else if (scanGrant)
        begin
            lastWinner <= SCAN;
        end
    end

    grantsExclusive: assert property (@(posedge aclk) disable iff (!resetn)
        !(hostGrant && scanGrant));

    // A held host write is served by the next cycle at the latest
    hostNotStarved: assert property (@(posedge aclk) disable iff (!resetn)
        hostReq.req |-> ##[0:1] hostGrant);

endmodule

// ==== scanoutReader.sv ====
// Raster scanout reader
`timescale 1ns/10ps
`include "lcdSubsystem_defines.svh"

module scanoutReader
(
    input  logic             aclk,
    input  logic             resetn,
    input  logic             grant,
    input  lcdPkg::pixel_t   rdata,
    output lcdPkg::memReq_t  memReq,
    output logic             streamValid,
    input  logic             streamReady,
    output lcdPkg::stream_t  stream
);
    import lcdPkg::*;

    localparam int FRAME_PIXELS = `FB_WIDTH * `FB_HEIGHT;
    localparam logic [`FB_ADDR_WIDTH-1:0] LAST_ADDR = `FB_ADDR_WIDTH'(FRAME_PIXELS - 1);

    logic [`FB_ADDR_WIDTH-1:0] addrReg;
    logic                      inFlight;
    stream_t                   streamReg;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            addrReg     <= '0;
            inFlight    <= 1'b0;
            streamValid <= 1'b0;
        end
        else
        begin
            if (grant)
            begin
                inFlight <= 1'b1;
            end
            // Memory answers one cycle after the grant
            if (inFlight)
            begin
                inFlight        <= 1'b0;
                streamValid     <= 1'b1;
                streamReg.pixel <= rdata;
                streamReg.last  <= (addrReg == LAST_ADDR);
                addrReg         <= (addrReg == LAST_ADDR) ? '0 : addrReg + 1'b1;
            end
            else if (streamValid && streamReady)
            begin
                streamValid <= 1'b0;
            end
        end
    end

    // Only one pixel in flight, ask again once the output register drains
    assign memReq = '{req: !streamValid && !inFlight, write: 1'b0, addr: addrReg, wdata: '0};
    assign stream = streamReg;

    streamHeld: assert property (@(posedge aclk) disable iff (!resetn)
        streamValid && !streamReady |=> streamValid && $stable(stream));

endmodule

// ==== tbLcdSubsystem.sv ====
// LCD subsystem testbench
`timescale 1ns/10ps
`include "lcdSubsystem_defines.svh"

module tbLcdSubsystem;
    import lcdPkg::*;

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 4;
    localparam int TICK_CYCLES  = `LCD_CLOCK_DIV + 1;
    localparam int INIT_BYTES   = 37;
    localparam int FRAME_PIXELS = `FB_WIDTH * `FB_HEIGHT;
    localparam int TICK_NS      = TICK_CYCLES * 2 * CLK_HALF;
    // Two ticks per init byte and at most six per pixel with the idle gap
    localparam int WATCHDOG_NS  = RESET_CYCLES * 2 * CLK_HALF
                                + (INIT_BYTES * 2 + 3 * FRAME_PIXELS * 6) * TICK_NS + 200;

    // Column and page end follow the 240x320 panel in the chosen rotation
    localparam bit         LANDSCAPE = `LCD_LANDSCAPE;
    // MADCTL bits for row/column exchange and BGR panel order
    localparam logic [7:0] MADCTL_MV  = 8'h20;
    localparam logic [7:0] MADCTL_BGR = 8'h08;
    localparam logic [7:0] ROTATION   = LANDSCAPE ? (MADCTL_MV | MADCTL_BGR) : MADCTL_BGR;
    localparam logic [15:0] COL_LAST  = LANDSCAPE ? 16'd319 : 16'd239;
    localparam logic [15:0] PAGE_LAST = LANDSCAPE ? 16'd239 : 16'd319;

    // Bit 8 is dc and is low for a command byte
    localparam logic [8:0] EXPECTED_INIT [INIT_BYTES] = '{
        9'h001, 9'h100, 9'h028, 9'h100, 9'h0C0, 9'h123, 9'h0C1, 9'h110,
        9'h0C5, 9'h12B, 9'h12B, 9'h0C7, 9'h1C0, 9'h036, {1'b1, ROTATION},
        9'h03A, 9'h155, 9'h0B1, 9'h100, 9'h11B, 9'h0B7, 9'h107,
        9'h011, 9'h100, 9'h029, 9'h100,
        9'h02A, 9'h100, 9'h100, {1'b1, COL_LAST[15:8]}, {1'b1, COL_LAST[7:0]},
        9'h02B, 9'h100, 9'h100, {1'b1, PAGE_LAST[15:8]}, {1'b1, PAGE_LAST[7:0]},
        9'h02C
    };

    logic                      aclk;
    logic                      resetn;
    logic                      hostWrite;
    logic [`FB_ADDR_WIDTH-1:0] hostAddr;
    pixel_t                    hostPixel;
    logic                      hostBusy;
    logic [7:0]                lcdData;
    logic                      lcdWr;
    logic                      lcdCs;
    logic                      lcdDc;

    pixel_t     shadow [FRAME_PIXELS];
    integer     seed = 36;
    int         byteIdx = 0;
    int         pixelCount = 0;
    int         phaseLen = 0;
    int         framesChecked = 0;
    int         lastAcceptCount = 0;
    logic       prevWr = 1'b1;
    logic [7:0] highByte;
    bit         checking = 1'b0;
    bit         quiet = 1'b0;

    lcdSubsystem UUT
    (
        .aclk      (aclk),
        .resetn    (resetn),
        .hostWrite (hostWrite),
        .hostAddr  (hostAddr),
        .hostPixel (hostPixel),
        .hostBusy  (hostBusy),
        .lcdData   (lcdData),
        .lcdWr     (lcdWr),
        .lcdCs     (lcdCs),
        .lcdDc     (lcdDc)
    );

    always #CLK_HALF aclk = ~aclk;

    task automatic valueMismatch(input string sigName, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sigName,
                 expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic stopOnError(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic writePixel(input logic [`FB_ADDR_WIDTH-1:0] addr, input pixel_t pix);
        hostWrite = 1'b1;
        hostAddr  = addr;
        hostPixel = pix;
        @(posedge aclk);
        #1;
        hostWrite = 1'b0;
        while (hostBusy)
        begin
            @(posedge aclk);
            #1;
        end
        shadow[addr]    = pix;
        lastAcceptCount = pixelCount;
    endtask

    resetValues: assert property (@(posedge aclk)
        $rose(resetn) |-> lcdWr && lcdCs && lcdDc && !hostBusy)
        else stopOnError("display pins or hostBusy wrong when reset was released");

    csStaysLow: assert property (@(posedge aclk) disable iff (!resetn)
        $past(resetn) |-> !lcdCs)
        else valueMismatch("lcdCs", 0, lcdCs);

    busyRises: assert property (@(posedge aclk) disable iff (!resetn)
        hostWrite && !hostBusy |=> hostBusy)
        else valueMismatch("hostBusy", 1, hostBusy);

    busyFalls: assert property (@(posedge aclk) disable iff (!resetn)
        $rose(hostBusy) |-> ##[1:2] !hostBusy)
        else stopOnError("host write was not granted within 3 cycles");

    // Display bus model taking each byte at the first edge that sees wr low
    always @(posedge aclk)
    begin
        bit innerGap;
        int pixAddr;
        if (resetn)
        begin
            if (lcdWr == prevWr)
            begin
                phaseLen++;
            end
            else if (!prevWr)
            begin
                assert (phaseLen == TICK_CYCLES)
                    else valueMismatch("lcdWr low cycles", TICK_CYCLES, phaseLen);
                phaseLen = 1;
            end
            else
            begin
                // High phase inside init or inside a pixel is exactly one tick
                innerGap = (byteIdx < INIT_BYTES)
                         || (byteIdx > INIT_BYTES && (byteIdx - INIT_BYTES) % 2 == 1);
                if (byteIdx > 0 && innerGap)
                begin
                    assert (phaseLen == TICK_CYCLES)
                        else valueMismatch("lcdWr high cycles", TICK_CYCLES, phaseLen);
                end
                else if (byteIdx > 0)
                begin
                    assert (phaseLen % TICK_CYCLES == 0)
                        else stopOnError("lcdWr idle phase not a whole number of ticks");
                end
                if (byteIdx < INIT_BYTES)
                begin
                    assert (lcdDc == EXPECTED_INIT[byteIdx][8])
                        else valueMismatch("lcdDc", EXPECTED_INIT[byteIdx][8], lcdDc);
                    assert (lcdData == EXPECTED_INIT[byteIdx][7:0])
                        else valueMismatch("lcdData", EXPECTED_INIT[byteIdx][7:0], lcdData);
                end
                else
                begin
                    assert (lcdDc) else valueMismatch("lcdDc", 1, lcdDc);
                    if ((byteIdx - INIT_BYTES) % 2 == 0)
                    begin
                        highByte = lcdData;
                    end
                    else
                    begin
                        pixAddr = pixelCount % FRAME_PIXELS;
                        // Reads run at most two pixels ahead of the bus
                        if (pixAddr == 0)
                        begin
                            checking = quiet && (pixelCount >= lastAcceptCount + 4);
                        end
                        if (checking)
                        begin
                            assert ({highByte, lcdData} == shadow[pixAddr])
                                else valueMismatch($sformatf("lcdData pixel %0d", pixAddr),
                                                   shadow[pixAddr], {highByte, lcdData});
                        end
                        if (checking && pixAddr == FRAME_PIXELS - 1)
                        begin
                            framesChecked++;
                        end
                        pixelCount++;
                    end
                end
                byteIdx++;
                phaseLen = 1;
            end
            prevWr = lcdWr;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        stopOnError("watchdog expired before a full frame was checked");
    end

    initial
    begin
        logic [31:0] rnd;
        logic [31:0] rndAddr;
        aclk      = 1'b0;
        resetn    = 1'b0;
        hostWrite = 1'b0;
        hostAddr  = '0;
        hostPixel = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        resetn = 1'b1;

        // Fill the whole frame
        for (int a = 0; a < FRAME_PIXELS; a++)
        begin
            rnd = $random(seed);
            writePixel(a[`FB_ADDR_WIDTH-1:0], rnd[15:0]);
        end

        // A few overwrites against live scanout
        while (pixelCount == 0)
        begin
            @(posedge aclk);
            #1;
        end
        repeat (4)
        begin
            rnd     = $random(seed);
            rndAddr = $random(seed);
            writePixel(rndAddr % FRAME_PIXELS, rnd[15:0]);
        end
        quiet = 1'b1;

        while (framesChecked == 0)
        begin
            @(posedge aclk);
            #1;
        end
        $display("Test passed");
        $finish;
    end

endmodule
